/* slow_bus_pkg.sv */
/*
 * slow bus package.
 * widths, word and address types, address map and constants
 * shared by the slow peripheral island.
 */
package slow_bus_pkg;

    // bus widths.
    localparam int data_w = 32;
    localparam int addr_w = 8;

    typedef logic [data_w-1:0] slow_word_t;
    typedef logic [addr_w-1:0] slow_addr_t;

    // register bank window.
    localparam slow_addr_t reg_base  = 8'h00;
    localparam int         reg_count = 8;
    localparam int         reg_idx_w = $clog2(reg_count);

    // mailbox addresses.
    localparam slow_addr_t mbox_data_addr = 8'h10;
    localparam slow_addr_t mbox_stat_addr = 8'h11;

    // mailbox sizing, depth must be a power of two.
    localparam int mbox_depth = 4;
    localparam int mbox_ptr_w = $clog2(mbox_depth);
    localparam int mbox_cnt_w = $clog2(mbox_depth + 1);

    // status word layout.
    localparam int mbox_ovf_bit = 8;

    // fixed read values.
    localparam slow_word_t dev_id        = 32'h51_0a_da_01;
    localparam slow_word_t unmapped_word = 32'hdead_beef;

endpackage

/* hl_adapter.sv */
/*
 * hl_adapter
 * carries single host reads and writes from clk_h into clk_l and returns
 * read data with a one-cycle ready strobe, using toggle handshakes.
 */
`timescale 1ns/1ps

module hl_adapter #(
    parameter int WIDTH = 32
) (
    input  logic                     clk_h,
    input  logic                     clk_l,
    input  logic                     rst_n,
    input  logic                     h_read_en,
    input  logic                     h_write_en,
    input  slow_bus_pkg::slow_addr_t h_addr,
    input  logic [WIDTH-1:0]         h_data_in,
    output logic                     h_data_ready,
    output logic [WIDTH-1:0]         h_data_out,
    output logic                     l_read_en,
    output logic                     l_write_en,
    output slow_bus_pkg::slow_addr_t l_addr,
    output logic [WIDTH-1:0]         l_data_in,
    input  logic [WIDTH-1:0]         l_data_out
);

    typedef enum logic [1:0] {H_IDLE, H_WAIT, H_READY} h_state_t;
    typedef enum logic [1:0] {L_IDLE, L_STROBE, L_CAPT} l_state_t;

    h_state_t h_state;
    l_state_t l_state;

    logic                     h_accept;
    logic                     hq_read;   // high for a latched read.
    slow_bus_pkg::slow_addr_t hq_addr;
    logic [WIDTH-1:0]         hq_wdata;
    logic [WIDTH-1:0]         l_rdata_q; // slow-side read capture.

    logic req_tgl, req_s1, req_s2, req_seen, req_new;
    logic done_tgl, done_s1, done_s2, done_seen, done_new;

    assign h_accept = (h_state == H_IDLE) && (h_read_en || h_write_en);
    assign done_new = done_s2 ^ done_seen;
    assign req_new  = req_s2 ^ req_seen;

    // fast side latches the request and waits for done.
    always_ff @(posedge clk_h or posedge rst_n) begin
        if (rst_n) begin
            h_state      <= H_IDLE;
            hq_read      <= 1'b0;
            req_tgl      <= 1'b0;
            done_s1      <= 1'b0;
            done_s2      <= 1'b0;
            done_seen    <= 1'b0;
            h_data_ready <= 1'b0;
            h_data_out   <= '0;
        end else begin
            done_s1      <= done_tgl;
            done_s2      <= done_s1;
            h_data_ready <= 1'b0;
            case (h_state)
                H_IDLE: begin
                    if (h_accept) begin
                        hq_read <= h_read_en;
                        req_tgl <= ~req_tgl;
                        h_state <= H_WAIT;
                    end
                end
                H_WAIT: begin
                    if (done_new) begin
                        done_seen    <= done_s2;
                        h_data_out   <= hq_read ? l_rdata_q : '0; // writes return zero.
                        h_data_ready <= 1'b1;
                        h_state      <= H_READY;
                    end
                end
                H_READY: h_state <= H_IDLE; // ready is high here.
                default: h_state <= H_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_h) begin
        if (h_accept) begin
            hq_addr  <= h_addr;
            hq_wdata <= h_data_in;
        end
    end

    // slow side gives one strobe cycle and one capture cycle before done.
    always_ff @(posedge clk_l or posedge rst_n) begin
        if (rst_n) begin
            l_state    <= L_IDLE;
            req_s1     <= 1'b0;
            req_s2     <= 1'b0;
            req_seen   <= 1'b0;
            done_tgl   <= 1'b0;
            l_read_en  <= 1'b0;
            l_write_en <= 1'b0;
        end else begin
            req_s1 <= req_tgl;
            req_s2 <= req_s1;
            case (l_state)
                L_IDLE: begin
                    if (req_new) begin
                        req_seen   <= req_s2;
                        l_read_en  <= hq_read;
                        l_write_en <= ~hq_read;
                        l_state    <= L_STROBE;
                    end
                end
                L_STROBE: begin
                    l_read_en  <= 1'b0;
                    l_write_en <= 1'b0;
                    l_state    <= L_CAPT;
                end
                L_CAPT: begin
                    done_tgl <= ~done_tgl; // l_rdata_q is stable from here.
                    l_state  <= L_IDLE;
                end
                default: l_state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_l) begin
        if (l_state == L_IDLE && req_new) begin
            l_addr    <= hq_addr;
            l_data_in <= hq_wdata;
        end
        if (l_state == L_STROBE) begin
            l_rdata_q <= l_data_out; // edge that ends the strobe.
        end
    end

    a_ready_one_cycle: assert property (@(posedge clk_h) disable iff (rst_n)
        h_data_ready |=> !h_data_ready);

    // both enables at once would be carried as a read.
    a_req_exclusive: assert property (@(posedge clk_h) disable iff (rst_n)
        !(h_read_en && h_write_en));

endmodule

/* slow_bus_mux.sv */
/*
 * slow bus decoder.
 * routes each slow strobe to the register bank or the mailbox and
 * muxes read data back, unmapped reads return a fixed word.
 */
`timescale 1ns/1ps

module slow_bus_mux (
    input  logic                                 clk_l,
    input  logic                                 rst_n,
    input  logic                                 l_read_en,
    input  logic                                 l_write_en,
    input  slow_bus_pkg::slow_addr_t             l_addr,
    input  slow_bus_pkg::slow_word_t             reg_rdata,
    input  slow_bus_pkg::slow_word_t             mb_rdata,
    output logic                                 reg_sel_rd,
    output logic                                 reg_sel_wr,
    output logic [slow_bus_pkg::reg_idx_w-1:0]   reg_index,
    output logic                                 mb_rd,
    output logic                                 mb_wr,
    output logic                                 mb_stat_sel,
    output slow_bus_pkg::slow_word_t             l_data_out
);

    slow_bus_pkg::slow_addr_t reg_off;
    logic                     reg_hit;
    logic                     mb_hit;

    // offset wraps high below the base, so one compare covers the window.
    assign reg_off   = l_addr - slow_bus_pkg::reg_base;
    assign reg_hit   = (reg_off < slow_bus_pkg::reg_count);
    assign reg_index = reg_off[slow_bus_pkg::reg_idx_w-1:0];

    assign mb_stat_sel = (l_addr == slow_bus_pkg::mbox_stat_addr);
    assign mb_hit      = (l_addr == slow_bus_pkg::mbox_data_addr) || mb_stat_sel;

    // strobes go to at most one device. unmapped writes fall away.
    assign reg_sel_rd = l_read_en && reg_hit;
    assign reg_sel_wr = l_write_en && reg_hit;
    assign mb_rd      = l_read_en && mb_hit;
    assign mb_wr      = l_write_en && mb_hit;

    always_comb begin
        if (reg_hit) begin
            l_data_out = reg_rdata;
        end else if (mb_hit) begin
            l_data_out = mb_rdata;
        end else begin
            l_data_out = slow_bus_pkg::unmapped_word; // no device here.
        end
    end

    a_one_select: assert property (@(posedge clk_l) disable iff (rst_n)
        $onehot0({reg_sel_rd, reg_sel_wr, mb_rd, mb_wr}));

endmodule

/* slow_reg_bank.sv */
/*
 * slow register bank.
 * eight words on clk_l, index 0 is a read-only device ID.
 */
`timescale 1ns/1ps

module slow_reg_bank (
    input  logic                               clk_l,
    input  logic                               rst_n,
    input  logic                               rd,
    input  logic                               wr,
    input  logic [slow_bus_pkg::reg_idx_w-1:0] index,
    input  slow_bus_pkg::slow_word_t           wdata,
    output slow_bus_pkg::slow_word_t           rdata
);

    // only indices 1 and up hold storage.
    slow_bus_pkg::slow_word_t regs [1:slow_bus_pkg::reg_count-1];

    logic wr_ok;

    assign wr_ok = wr && (index != '0); // id ignores writes.

    always_ff @(posedge clk_l or posedge rst_n) begin
        if (rst_n) begin
            for (int i = 1; i < slow_bus_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[index] <= wdata;
        end
    end

    always_comb begin
        if (!rd) begin
            rdata = '0;
        end else if (index == '0) begin
            rdata = slow_bus_pkg::dev_id;
        end else begin
            rdata = regs[index];
        end
    end

endmodule

/* slow_mailbox.sv */
/*
 * slow mailbox.
 * four-deep FIFO behind a data address, with a status word holding
 * the fill count and a sticky overflow flag.
 */
`timescale 1ns/1ps

module slow_mailbox (
    input  logic                     clk_l,
    input  logic                     rst_n,
    input  logic                     rd,
    input  logic                     wr,
    input  logic                     stat_sel,
    input  slow_bus_pkg::slow_word_t wdata,
    output slow_bus_pkg::slow_word_t rdata
);

    slow_bus_pkg::slow_word_t mem [slow_bus_pkg::mbox_depth];

    logic [slow_bus_pkg::mbox_ptr_w-1:0] wr_ptr;
    logic [slow_bus_pkg::mbox_ptr_w-1:0] rd_ptr;
    logic [slow_bus_pkg::mbox_cnt_w-1:0] count;
    logic                                ovf;
    logic                                full;
    logic                                empty;
    logic                                push;
    logic                                pop;
    slow_bus_pkg::slow_word_t            stat_word;

    assign full  = (count == slow_bus_pkg::mbox_depth);
    assign empty = (count == '0);
    assign push  = wr && !stat_sel && !full;
    assign pop   = rd && !stat_sel && !empty;

    always_ff @(posedge clk_l or posedge rst_n) begin
        if (rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (wr && stat_sel) begin
                ovf <= 1'b0; // any status write clears.
            end else if (wr && full) begin
                ovf <= 1'b1; // word is dropped.
            end
        end
    end

    always_ff @(posedge clk_l) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_comb begin
        stat_word = '0;
        stat_word[slow_bus_pkg::mbox_cnt_w-1:0] = count;
        stat_word[slow_bus_pkg::mbox_ovf_bit]   = ovf;
    end

    // pop happens on the same edge the adapter samples this.
    always_comb begin
        if (!rd) begin
            rdata = '0;
        end else if (stat_sel) begin
            rdata = stat_word;
        end else if (empty) begin
            rdata = '0;
        end else begin
            rdata = mem[rd_ptr];
        end
    end

    a_count_bound: assert property (@(posedge clk_l) disable iff (rst_n)
        count <= slow_bus_pkg::mbox_depth);

endmodule

/* slow_io_top.sv */
/*
 * slow io top.
 * host adapter, slow bus decoder, register bank and mailbox.
 */
`timescale 1ns/1ps

module slow_io_top (
    input  logic                     clk_h,
    input  logic                     clk_l,
    input  logic                     rst_n,
    input  logic                     h_read_en,
    input  logic                     h_write_en,
    input  slow_bus_pkg::slow_addr_t h_addr,
    input  slow_bus_pkg::slow_word_t h_data_in,
    output logic                     h_data_ready,
    output slow_bus_pkg::slow_word_t h_data_out
);

    // slow bus.
    logic                               l_read_en;
    logic                               l_write_en;
    slow_bus_pkg::slow_addr_t           l_addr;
    slow_bus_pkg::slow_word_t           l_data_in;
    slow_bus_pkg::slow_word_t           l_data_out;

    // device side.
    logic                               reg_sel_rd;
    logic                               reg_sel_wr;
    logic [slow_bus_pkg::reg_idx_w-1:0] reg_index;
    slow_bus_pkg::slow_word_t           reg_rdata;
    logic                               mb_rd;
    logic                               mb_wr;
    logic                               mb_stat_sel;
    slow_bus_pkg::slow_word_t           mb_rdata;

    hl_adapter #(
        .WIDTH(slow_bus_pkg::data_w)
    ) adapter0 (
        .clk_h       (clk_h),
        .clk_l       (clk_l),
        .rst_n       (rst_n),
        .h_read_en   (h_read_en),
        .h_write_en  (h_write_en),
        .h_addr      (h_addr),
        .h_data_in   (h_data_in),
        .h_data_ready(h_data_ready),
        .h_data_out  (h_data_out),
        .l_read_en   (l_read_en),
        .l_write_en  (l_write_en),
        .l_addr      (l_addr),
        .l_data_in   (l_data_in),
        .l_data_out  (l_data_out)
    );

    slow_bus_mux mux0 (
        .clk_l      (clk_l),
        .rst_n      (rst_n),
        .l_read_en  (l_read_en),
        .l_write_en (l_write_en),
        .l_addr     (l_addr),
        .reg_rdata  (reg_rdata),
        .mb_rdata   (mb_rdata),
        .reg_sel_rd (reg_sel_rd),
        .reg_sel_wr (reg_sel_wr),
        .reg_index  (reg_index),
        .mb_rd      (mb_rd),
        .mb_wr      (mb_wr),
        .mb_stat_sel(mb_stat_sel),
        .l_data_out (l_data_out)
    );

    slow_reg_bank regs0 (
        .clk_l(clk_l),
        .rst_n(rst_n),
        .rd   (reg_sel_rd),
        .wr   (reg_sel_wr),
        .index(reg_index),
        .wdata(l_data_in),
        .rdata(reg_rdata)
    );

    slow_mailbox mbox0 (
        .clk_l   (clk_l),
        .rst_n   (rst_n),
        .rd      (mb_rd),
        .wr      (mb_wr),
        .stat_sel(mb_stat_sel),
        .wdata   (l_data_in),
        .rdata   (mb_rdata)
    );

endmodule

/* tb_slow_io.sv */
/*
 * testbench for slow_io_top.
 * builds a table of host reads and writes with expected data from simple
 * register and mailbox models, applies it and checks each response.
 */
`timescale 1ns/1ps

module tb_slow_io;

    typedef struct packed {
        logic                     is_wr;
        slow_bus_pkg::slow_addr_t addr;
        slow_bus_pkg::slow_word_t wdata;
        slow_bus_pkg::slow_word_t exp_data;
    } step_t;

    logic                     clk_h;
    logic                     clk_l;
    logic                     rst_n;
    logic                     h_read_en;
    logic                     h_write_en;
    slow_bus_pkg::slow_addr_t h_addr;
    slow_bus_pkg::slow_word_t h_data_in;
    logic                     h_data_ready;
    slow_bus_pkg::slow_word_t h_data_out;

    step_t                    steps[$];
    slow_bus_pkg::slow_word_t reg_model[slow_bus_pkg::reg_count]; // expected bank contents.
    slow_bus_pkg::slow_word_t mail_q[$];                          // expected fifo contents.
    logic                     mail_ovf;
    logic [31:0]              lcg_state;
    int                       check_count;
    int                       err_count;
    int                       timeout_count;

    slow_io_top dut0 (
        .clk_h       (clk_h),
        .clk_l       (clk_l),
        .rst_n       (rst_n),
        .h_read_en   (h_read_en),
        .h_write_en  (h_write_en),
        .h_addr      (h_addr),
        .h_data_in   (h_data_in),
        .h_data_ready(h_data_ready),
        .h_data_out  (h_data_out)
    );

    initial begin
        clk_h = 1'b0;
        forever #5 clk_h = ~clk_h;
    end

    initial begin
        clk_l = 1'b0;
        forever #18.5 clk_l = ~clk_l; // 37 ns period.
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // count in bits 2:0 and overflow in bit 8.
    function automatic slow_bus_pkg::slow_word_t status_word(input int cnt, input logic ovf);
        slow_bus_pkg::slow_word_t w;
        w = '0;
        w[2:0] = cnt[2:0];
        w[8] = ovf;
        return w;
    endfunction

    task automatic check_word(input slow_bus_pkg::slow_word_t got,
                              input slow_bus_pkg::slow_word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic stage_write(input slow_bus_pkg::slow_addr_t addr,
                               input slow_bus_pkg::slow_word_t data);
        steps.push_back('{1'b1, addr, data, '0});
        if (addr >= 1 && addr < slow_bus_pkg::reg_count) begin
            reg_model[addr] = data; // id and unmapped writes are dropped.
        end
    endtask

    task automatic expect_read(input slow_bus_pkg::slow_addr_t addr,
                               input slow_bus_pkg::slow_word_t exp);
        steps.push_back('{1'b0, addr, '0, exp});
    endtask

    task automatic push_mail(input slow_bus_pkg::slow_word_t data);
        steps.push_back('{1'b1, slow_bus_pkg::mbox_data_addr, data, '0});
        if (mail_q.size() < slow_bus_pkg::mbox_depth) begin
            mail_q.push_back(data);
        end else begin
            mail_ovf = 1'b1; // word is lost when full.
        end
    endtask

    task automatic pop_mail();
        if (mail_q.size() == 0) begin
            expect_read(slow_bus_pkg::mbox_data_addr, '0);
        end else begin
            expect_read(slow_bus_pkg::mbox_data_addr, mail_q.pop_front());
        end
    endtask

    task automatic read_status();
        expect_read(slow_bus_pkg::mbox_stat_addr, status_word(mail_q.size(), mail_ovf));
    endtask

    task automatic clear_overflow();
        steps.push_back('{1'b1, slow_bus_pkg::mbox_stat_addr, 32'h0000_0001, '0});
        mail_ovf = 1'b0;
    endtask

    task automatic build_table();
        for (int i = 0; i < slow_bus_pkg::reg_count; i++) begin
            reg_model[i] = '0;
        end
        mail_ovf = 1'b0;
        // state after reset.
        for (int i = 1; i < slow_bus_pkg::reg_count; i++) expect_read(i, '0);
        read_status();
        // register bank write and read back.
        for (int i = 1; i < slow_bus_pkg::reg_count; i++) begin
            lcg_state = lcg_next(lcg_state);
            stage_write(i, lcg_state);
        end
        for (int i = 1; i < slow_bus_pkg::reg_count; i++) expect_read(i, reg_model[i]);
        stage_write(8'h00, 32'h1234_5678);
        expect_read(8'h00, slow_bus_pkg::dev_id);
        // unmapped addresses.
        expect_read(8'h20, slow_bus_pkg::unmapped_word);
        stage_write(8'h25, 32'h0bad_f00d); // low bits point at register 5.
        for (int i = 1; i < slow_bus_pkg::reg_count; i++) expect_read(i, reg_model[i]);
        expect_read(8'h25, slow_bus_pkg::unmapped_word);
        // mailbox order with the count falling 3 to 0.
        for (int i = 0; i < 3; i++) begin
            lcg_state = lcg_next(lcg_state);
            push_mail(lcg_state);
        end
        read_status();
        for (int i = 0; i < 3; i++) begin
            pop_mail();
            read_status();
        end
        // overflow, empty pop and clear.
        for (int i = 0; i < 5; i++) begin
            lcg_state = lcg_next(lcg_state);
            push_mail(lcg_state);
        end
        read_status();
        for (int i = 0; i < 5; i++) pop_mail(); // last one finds it empty.
        read_status();
        clear_overflow();
        read_status();
    endtask

    // one host transfer held until ready.
    task automatic do_transfer(input step_t s);
        int  wait_cnt;
        logic seen;
        @(negedge clk_h);
        h_addr     = s.addr;
        h_data_in  = s.wdata;
        h_write_en = s.is_wr;
        h_read_en  = !s.is_wr;
        wait_cnt   = 0;
        seen       = 1'b0;
        while (!seen && wait_cnt < 300) begin
            @(negedge clk_h);
            wait_cnt++;
            seen = h_data_ready;
        end
        h_read_en  = 1'b0;
        h_write_en = 1'b0;
        if (!seen) begin
            timeout_count++;
            $display("timeout: no ready within 300 cycles for access to address %h", s.addr);
        end else begin
            if (s.is_wr) begin
                check_word(h_data_out, '0, $sformatf("write response at %h", s.addr));
            end else begin
                check_word(h_data_out, s.exp_data, $sformatf("read of %h", s.addr));
            end
            @(negedge clk_h);
            check_flag(h_data_ready, 1'b0, "ready after one cycle");
        end
    endtask

    initial begin
        rst_n         = 1'b1; // active high.
        h_read_en     = 1'b0;
        h_write_en    = 1'b0;
        h_addr        = '0;
        h_data_in     = '0;
        lcg_state     = 32'h823d;
        check_count   = 0;
        err_count     = 0;
        timeout_count = 0;
        build_table();
        repeat (10) @(negedge clk_h);
        rst_n = 1'b0;
        check_flag(h_data_ready, 1'b0, "ready low after reset");
        foreach (steps[i]) do_transfer(steps[i]);
        repeat (2) @(negedge clk_h);
        $display("checks %0d, value errors %0d, timeouts %0d",
                 check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
slow_bus_pkg.sv
hl_adapter.sv
slow_bus_mux.sv
slow_reg_bank.sv
slow_mailbox.sv
slow_io_top.sv
tb_slow_io.sv

/* Bender.yml */
package:
  name: slow_io

sources:
  - slow_bus_pkg.sv
  - hl_adapter.sv
  - slow_bus_mux.sv
  - slow_reg_bank.sv
  - slow_mailbox.sv
  - slow_io_top.sv
  - target: test
    files:
      - tb_slow_io.sv
